//--- logic/exu_pkg.sv
package exu_pkg;

    typedef logic [63:0] xlen_t;    // operand / result
    typedef logic [31:0] half_t;    // word variant value
    typedef logic [6:0]  cnt_t;     // iteration count, up to 64

    typedef enum logic [4:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLL,
        OP_SRL,
        OP_SRA,
        OP_SLT,
        OP_SLTU,
        OP_BEQ,
        OP_BNE,
        OP_BLT,
        OP_BGE,
        OP_BLTU,
        OP_BGEU,
        OP_MUL,     // low half of product
        OP_DIVU,
        OP_REMU
    } alu_op_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ITER,    // load cycle plus the step cycles
        ST_FINISH   // result capture
    } exu_state_t;

    typedef enum logic [1:0] {
        SRC_ALU,
        SRC_MUL,
        SRC_DIV
    } src_sel_t;

endpackage

//--- logic/iter_if.sv
`timescale 1ns/1ps

interface iter_if;

    logic load;     // counter and datapaths take their start values
    logic step;     // one iteration
    logic word;     // 32 iterations instead of 64
    logic last;     // final step in progress
    logic is_div;   // divider owns this operation

    modport ctrl (output load, output step, output word, output is_div, input last);

    modport counter (input load, input step, input word, output last);

    modport datapath (input load, input step, input word, input is_div);

endinterface

//--- logic/alu_comb.sv
`timescale 1ns/1ps

module alu_comb import exu_pkg::*; (
    input  alu_op_t op,
    input  logic    word,
    input  xlen_t   a,
    input  xlen_t   b,
    output xlen_t   res,
    output logic    cond
);

    logic [5:0] shamt;
    half_t      a_lo;
    half_t      b_lo;
    xlen_t      cmp_a;
    xlen_t      cmp_b;
    logic       eq;
    logic       lt;
    logic       ltu;

    assign a_lo = a[31:0];
    assign b_lo = b[31:0];

    // word shifts only look at 5 bits
    assign shamt = word ? {1'b0, b[4:0]} : b[5:0];

    // word compares work on the sign-extended low halves
    assign cmp_a = word ? {{32{a_lo[31]}}, a_lo} : a;
    assign cmp_b = word ? {{32{b_lo[31]}}, b_lo} : b;

    assign eq  = (cmp_a == cmp_b);
    assign lt  = ($signed(cmp_a) < $signed(cmp_b));
    assign ltu = (cmp_a < cmp_b);

    always_comb begin
        res = '0;   // mul/div come from the sequential units
        case (op)
            OP_ADD:  res = a + b;
            OP_SUB:  res = a - b;
            OP_AND:  res = a & b;
            OP_OR:   res = a | b;
            OP_XOR:  res = a ^ b;
            OP_SLL:  res = a << shamt;
            OP_SRL: begin
                // word form shifts the low half in with zeros
                if (word)
                    res = {32'h0, a_lo} >> shamt;
                else
                    res = a >> shamt;
            end
            OP_SRA: begin
                if (word)
                    res = $signed({{32{a_lo[31]}}, a_lo}) >>> shamt;
                else
                    res = $signed(a) >>> shamt;
            end
            OP_SLT:  res = {63'h0, lt};
            OP_SLTU: res = {63'h0, ltu};
            default: res = '0;
        endcase
    end

    always_comb begin
        case (op)
            OP_BEQ:  cond = eq;
            OP_BNE:  cond = !eq;
            OP_BLT:  cond = lt;
            OP_BGE:  cond = !lt;
            OP_BLTU: cond = ltu;
            OP_BGEU: cond = !ltu;
            default: cond = 1'b0;   // not a branch
        endcase
    end

endmodule

//--- logic/mul_shift_add.sv
`timescale 1ns/1ps

module mul_shift_add import exu_pkg::*; (
    input  logic          clk,
    input  logic          rst_n,
    iter_if.datapath      it,
    input  xlen_t         a,
    input  xlen_t         b,
    output xlen_t         product
);

    xlen_t mcand;   // shifts left each step
    xlen_t mplier;  // shifts right, bit 0 decides the add
    xlen_t acc;

    logic active;

    assign active = !it.is_div;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mcand  <= '0;
            mplier <= '0;
            acc    <= '0;
        end else if (active && it.load) begin
            acc <= '0;
            // upper bits never reach the low 32 in word mode
            mcand  <= it.word ? {32'h0, a[31:0]} : a;
            mplier <= it.word ? {32'h0, b[31:0]} : b;
        end else if (active && it.step) begin
            if (mplier[0])
                acc <= acc + mcand;
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    // only the low 64 bits are kept, wraps naturally
    assign product = acc;

endmodule

//--- logic/div_restoring.sv
`timescale 1ns/1ps

module div_restoring import exu_pkg::*; (
    input  logic          clk,
    input  logic          rst_n,
    iter_if.datapath      it,
    input  xlen_t         a,
    input  xlen_t         b,
    output xlen_t         quotient,
    output xlen_t         remainder
);

    xlen_t       rem;   // partial remainder
    xlen_t       quo;   // dividend bits out the top, quotient bits in the bottom
    xlen_t       dvsr;
    logic [64:0] part;  // remainder shifted with the next dividend bit
    logic [64:0] diff;
    logic        fits;
    logic        active;

    assign active = it.is_div;

    assign part = {rem, quo[63]};
    assign diff = part - {1'b0, dvsr};
    assign fits = (part >= {1'b0, dvsr});   // zero divisor always fits

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rem  <= '0;
            quo  <= '0;
            dvsr <= '0;
        end else if (active && it.load) begin
            rem <= '0;
            // word dividend sits in the top half so 32 steps consume it
            quo  <= it.word ? {a[31:0], 32'h0} : a;
            dvsr <= it.word ? {32'h0, b[31:0]} : b;
        end else if (active && it.step) begin
            // restore by simply keeping the shifted value
            if (fits)
                rem <= diff[63:0];
            else
                rem <= part[63:0];
            quo <= {quo[62:0], fits};
        end
    end

    assign quotient  = quo;
    assign remainder = rem;

endmodule

//--- logic/iter_counter.sv
`timescale 1ns/1ps

module iter_counter import exu_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    iter_if.counter  it
);

    cnt_t cnt;  // iterations still to run

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            cnt <= '0;
        else if (it.load)
            cnt <= it.word ? cnt_t'(32) : cnt_t'(64);
        else if (it.step && cnt != '0)
            cnt <= cnt - 1'b1;
    end

    // one iteration left means this step is the final one
    assign it.last = (cnt == cnt_t'(1));

endmodule

//--- logic/exu_ctrl.sv
`timescale 1ns/1ps

module exu_ctrl import exu_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     start,
    input  alu_op_t  op,
    input  logic     word,
    input  xlen_t    src1,
    input  xlen_t    src2,
    iter_if.ctrl     it,
    output alu_op_t  op_q,
    output logic     word_q,
    output xlen_t    src1_q,
    output xlen_t    src2_q,
    output src_sel_t sel,
    output logic     capture,
    output logic     busy,
    output logic     done
);

    exu_state_t state;
    exu_state_t state_nxt;
    logic       accept;
    logic       iter_op;
    logic       load_q;     // first ITER cycle is the load cycle
    logic       done_q;

    assign accept  = start && (state == ST_IDLE) && !done_q;
    assign iter_op = (op == OP_MUL) || (op == OP_DIVU) || (op == OP_REMU);

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE:   if (accept) state_nxt = iter_op ? ST_ITER : ST_FINISH;
            ST_ITER:   if (it.step && it.last) state_nxt = ST_FINISH;
            ST_FINISH: state_nxt = ST_IDLE;
            default:   state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= ST_IDLE;
            load_q <= 1'b0;
            done_q <= 1'b0;
            op_q   <= OP_ADD;
            word_q <= 1'b0;
        end else begin
            state  <= state_nxt;
            load_q <= accept && iter_op;
            done_q <= (state == ST_FINISH);
            if (accept) begin
                op_q   <= op;
                word_q <= word;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            src1_q <= src1;
            src2_q <= src2;
        end
    end

    assign it.load   = load_q;
    assign it.step   = (state == ST_ITER) && !load_q;
    assign it.word   = word_q;
    assign it.is_div = (op_q == OP_DIVU) || (op_q == OP_REMU);

    always_comb begin
        case (op_q)
            OP_MUL:           sel = SRC_MUL;
            OP_DIVU, OP_REMU: sel = SRC_DIV;
            default:          sel = SRC_ALU;
        endcase
    end

    assign capture = (state == ST_FINISH);
    assign done    = done_q;
    assign busy    = (state != ST_IDLE) || done_q;   // stays up through done

endmodule

//--- logic/result_stage.sv
`timescale 1ns/1ps

module result_stage import exu_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     capture,
    input  src_sel_t sel,
    input  alu_op_t  op,
    input  logic     word,
    input  xlen_t    alu_res,
    input  xlen_t    product,
    input  xlen_t    quotient,
    input  xlen_t    remainder,
    input  logic     cond,
    output xlen_t    result,
    output logic     taken
);

    xlen_t raw;
    half_t raw_lo;
    xlen_t ext;
    logic  is_branch;

    always_comb begin
        case (sel)
            SRC_MUL: raw = product;
            SRC_DIV: raw = (op == OP_REMU) ? remainder : quotient;
            default: raw = alu_res;
        endcase
    end

    assign is_branch = op inside {OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU};
    assign raw_lo    = raw[31:0];

    // word results are the low half sign-extended
    assign ext = (word && !is_branch) ? {{32{raw_lo[31]}}, raw_lo} : raw;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result <= '0;
            taken  <= 1'b0;
        end else if (capture) begin
            result <= ext;
            taken  <= cond;
        end
    end

endmodule

//--- logic/exu_top.sv
`timescale 1ns/1ps

module exu_top import exu_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    start,
    input  alu_op_t op,
    input  logic    word,
    input  xlen_t   src1,
    input  xlen_t   src2,
    output xlen_t   result,
    output logic    taken,
    output logic    busy,
    output logic    done
);

    alu_op_t  op_q;
    logic     word_q;
    xlen_t    src1_q;
    xlen_t    src2_q;
    src_sel_t sel;
    logic     capture;
    xlen_t    alu_res;
    logic     cond;
    xlen_t    product;
    xlen_t    quotient;
    xlen_t    remainder;

    iter_if it_bus ();

    exu_ctrl ctrl_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .start   (start),
        .op      (op),
        .word    (word),
        .src1    (src1),
        .src2    (src2),
        .it      (it_bus.ctrl),
        .op_q    (op_q),
        .word_q  (word_q),
        .src1_q  (src1_q),
        .src2_q  (src2_q),
        .sel     (sel),
        .capture (capture),
        .busy    (busy),
        .done    (done)
    );

    iter_counter counter_inst (.clk(clk), .rst_n(rst_n), .it(it_bus.counter));

    alu_comb alu_inst (.op(op_q), .word(word_q), .a(src1_q), .b(src2_q), .res(alu_res), .cond(cond));

    mul_shift_add mul_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .it      (it_bus.datapath),
        .a       (src1_q),
        .b       (src2_q),
        .product (product)
    );

    div_restoring div_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .it        (it_bus.datapath),
        .a         (src1_q),
        .b         (src2_q),
        .quotient  (quotient),
        .remainder (remainder)
    );

    result_stage result_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .capture   (capture),
        .sel       (sel),
        .op        (op_q),
        .word      (word_q),
        .alu_res   (alu_res),
        .product   (product),
        .quotient  (quotient),
        .remainder (remainder),
        .cond      (cond),
        .result    (result),
        .taken     (taken)
    );

endmodule

//--- bench/exu_tb.sv
`timescale 1ns/1ps

module exu_tb import exu_pkg::*; ();

    localparam int MAX_CYCLES = 20000;  // ~200 ops, the longest 68 cycles each, plus margin

    logic    clk;
    logic    rst_n;
    logic    start;
    alu_op_t op;
    logic    word;
    xlen_t   src1;
    xlen_t   src2;
    xlen_t   result;
    logic    taken;
    logic    busy;
    logic    done;

    int          cycle_cnt = 0;

    exu_top exu_top_inst (
        .clk    (clk),
        .rst_n  (rst_n),
        .start  (start),
        .op     (op),
        .word   (word),
        .src1   (src1),
        .src2   (src2),
        .result (result),
        .taken  (taken),
        .busy   (busy),
        .done   (done)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;   // 8 ns period

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1, "run stopped at the first error");
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES)
            abort_run($sformatf("timeout: run still going after %0d clock cycles", MAX_CYCLES));
    end

    task automatic check_value(input string name, input xlen_t got, input xlen_t exp);
        assert (got === exp) else begin
            abort_run($sformatf("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        assert (got === exp) else begin
            abort_run($sformatf("[ERROR] %0t %s: got %b, expected %b", $time, name, got, exp));
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        assert (got == exp) else begin
            abort_run($sformatf("[ERROR] %0t %s: got %0d, expected %0d", $time, name, got, exp));
        end
    endtask

    function automatic xlen_t sext32(input half_t v);
        return {{32{v[31]}}, v};
    endfunction

    function automatic xlen_t rand64();
        return {$urandom(), $urandom()};
    endfunction

    // reference model of one operation
    function automatic void expected_outcome(input alu_op_t f, input logic w, input xlen_t a,
                                             input xlen_t b, output xlen_t r, output logic t);
        xlen_t      sa;
        xlen_t      sb;
        xlen_t      ua;
        xlen_t      ub;
        logic [5:0] sh;
        sa = w ? sext32(a[31:0]) : a;
        sb = w ? sext32(b[31:0]) : b;
        ua = w ? {32'h0, a[31:0]} : a;  // divider sees zero-extended halves
        ub = w ? {32'h0, b[31:0]} : b;
        sh = w ? {1'b0, b[4:0]} : b[5:0];
        r = '0;     // branches leave no result
        t = 1'b0;
        case (f)
            OP_ADD:  r = a + b;
            OP_SUB:  r = a - b;
            OP_AND:  r = a & b;
            OP_OR:   r = a | b;
            OP_XOR:  r = a ^ b;
            OP_SLL:  r = a << sh;
            OP_SRL:  r = ua >> sh;
            OP_SRA:  r = $signed(sa) >>> sh;
            OP_SLT:  r = {63'h0, ($signed(sa) < $signed(sb))};
            OP_SLTU: r = {63'h0, (sa < sb)};
            OP_BEQ:  t = (sa == sb);
            OP_BNE:  t = (sa != sb);
            OP_BLT:  t = ($signed(sa) < $signed(sb));
            OP_BGE:  t = ($signed(sa) >= $signed(sb));
            OP_BLTU: t = (sa < sb);
            OP_BGEU: t = (sa >= sb);
            OP_MUL:  r = a * b;
            OP_DIVU: r = (ub == '0) ? '1 : ua / ub;     // x/0 gives all ones
            OP_REMU: r = (ub == '0) ? ua : ua % ub;
            default: r = '0;
        endcase
        if (w && !(f inside {OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU}))
            r = sext32(r[31:0]);
    endfunction

    // one operation from start pulse to done, then back to idle
    task automatic run_op(input alu_op_t f, input logic w, input xlen_t a, input xlen_t b);
        xlen_t exp_res;
        logic  exp_taken;
        int    lat;
        int    want_lat;
        expected_outcome(f, w, a, b, exp_res, exp_taken);
        want_lat = 1;
        if (f inside {OP_MUL, OP_DIVU, OP_REMU})
            want_lat = w ? 34 : 66;     // load + steps + finish
        @(posedge clk);
        start <= 1'b1;
        op    <= f;
        word  <= w;
        src1  <= a;
        src2  <= b;
        @(posedge clk);
        start <= 1'b0;
        lat = 0;
        do begin
            @(posedge clk);
            lat++;
            @(negedge clk);
            check_flag("busy", busy, 1'b1);
        end while (!done);
        check_count("done latency", lat, want_lat);
        check_value("result", result, exp_res);
        check_flag("taken", taken, exp_taken);
        @(negedge clk);
        check_flag("done after pulse", done, 1'b0);
        check_flag("busy after done", busy, 1'b0);
    endtask

    task automatic test_reset_and_alu();
        check_value("result after reset", result, '0);
        check_flag("busy after reset", busy, 1'b0);
        check_flag("done after reset", done, 1'b0);
        check_flag("taken after reset", taken, 1'b0);
        for (int i = 0; i <= int'(OP_SLTU); i++) begin
            for (int w = 0; w < 2; w++) begin
                run_op(alu_op_t'(i), w[0], 64'h8000_0001_7fff_ff85, 64'h0000_0000_0000_0027);
                run_op(alu_op_t'(i), w[0], 64'hffff_ffff_ffff_fffe, 64'h0000_0000_0000_0001);
                repeat (2) run_op(alu_op_t'(i), w[0], rand64(), rand64());
            end
        end
    endtask

    task automatic test_branches();
        alu_op_t br [6] = '{OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU};
        xlen_t   x;
        foreach (br[i]) begin
            for (int w = 0; w < 2; w++) begin
                x = rand64();
                run_op(br[i], w[0], x, x);  // equal
                run_op(br[i], w[0], 64'hffff_ffff_ffff_fffb, 64'h0000_0000_0000_0003);
                run_op(br[i], w[0], 64'h0000_0000_0000_0003, 64'hffff_ffff_ffff_fffb);
                run_op(br[i], w[0], 64'hffff_ffff_ffff_fff0, 64'h0000_0000_8000_0000);
            end
        end
        run_op(OP_BEQ, 1'b0, 64'h1, 64'h1);
        run_op(OP_XOR, 1'b0, 64'h1, 64'h1);     // taken must drop again
        check_flag("taken on non-branch", taken, 1'b0);
    endtask

    task automatic test_multiply();
        xlen_t edges [4] = '{64'h0, '1, 64'h8000_0000_0000_0000, 64'h0000_0000_8000_0000};
        for (int w = 0; w < 2; w++) begin
            foreach (edges[i]) begin
                foreach (edges[j])
                    run_op(OP_MUL, w[0], edges[i], edges[j]);
                run_op(OP_MUL, w[0], edges[i], rand64());
            end
            repeat (3) run_op(OP_MUL, w[0], rand64(), rand64());
        end
    endtask

    task automatic test_divide();
        alu_op_t f;
        for (int w = 0; w < 2; w++) begin
            for (int k = 0; k < 2; k++) begin
                f = (k == 0) ? OP_DIVU : OP_REMU;
                repeat (3) run_op(f, w[0], rand64(), rand64());
                run_op(f, w[0], rand64(), rand64() >> 40);  // small divisor
                run_op(f, w[0], rand64(), 64'h0);
                run_op(f, w[0], rand64(), 64'hdead_beef_0000_0000);   // zero low half
            end
        end
    endtask

    task automatic test_start_while_busy();
        xlen_t a;
        xlen_t b;
        xlen_t exp_res;
        logic  exp_taken;
        int    dones;
        logic  was_done;
        a = rand64();
        b = rand64();
        expected_outcome(OP_MUL, 1'b0, a, b, exp_res, exp_taken);
        @(posedge clk);
        start <= 1'b1;
        op    <= OP_MUL;
        word  <= 1'b0;
        src1  <= a;
        src2  <= b;
        @(posedge clk);
        start <= 1'b0;
        repeat (10) @(posedge clk);
        start <= 1'b1;      // second start in the middle of the multiply
        op    <= OP_ADD;
        src1  <= ~a;
        @(posedge clk);
        start <= 1'b0;
        dones = 0;
        was_done = 1'b0;
        repeat (80) begin
            @(negedge clk);
            if (was_done)
                check_flag("busy after done", busy, 1'b0);
            if (done) begin
                dones++;
                check_value("result", result, exp_res);
                check_flag("taken", taken, exp_taken);
            end
            was_done = done;
        end
        check_count("done pulses", dones, 1);
        check_flag("busy", busy, 1'b0);
        check_value("result held", result, exp_res);
    endtask

    initial begin
        void'($urandom(34691));
        rst_n = 1'b0;
        start = 1'b0;
        op    = OP_ADD;
        word  = 1'b0;
        src1  = '0;
        src2  = '0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        test_reset_and_alu();
        test_branches();
        test_multiply();
        test_divide();
        test_start_while_busy();
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

//--- project.f
logic/exu_pkg.sv
logic/iter_if.sv
logic/alu_comb.sv
logic/mul_shift_add.sv
logic/div_restoring.sv
logic/iter_counter.sv
logic/exu_ctrl.sv
logic/result_stage.sv
logic/exu_top.sv
bench/exu_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build the execute unit testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module exu_tb -o exu_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/exu_sim 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qF -- "*** TEST PASSED ***"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1
